// File: common/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // fetch geometry
    //////////////////////////////////////////////////////////////////////

    // bytes in one instruction line
    localparam int LINE_BYTES = 16;

    // lines held by the instruction buffer
    localparam int NUM_SLOTS = 4;

    // byte offset inside the 64-byte window
    localparam int WINDOW_BITS = 6;

    localparam int ADDR_W = 32;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // lowest address byte sits in bits 7:0
    typedef logic [8*LINE_BYTES-1:0] line_t;

    typedef logic [ADDR_W-1:0] addr_t;

endpackage

// File: design/line_fetcher.sv
module line_fetcher import fetch_pkg::*; #(
    parameter addr_t RESET_ADDR = '0
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 redirect,
    input  addr_t                redirect_addr,

    input  logic [NUM_SLOTS-1:0] slot_valid,

    output addr_t                paddr,
    output logic                 psel,
    output logic                 penable,
    input  logic [31:0]          prdata,
    input  logic                 pready,

    output logic                 fill_valid,
    output logic [1:0]           fill_slot,
    output line_t                fill_line
);

    localparam int OFS_BITS = $clog2(LINE_BYTES);
    localparam int WORDS = LINE_BYTES / 4;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_t;

    state_t     state;
    addr_t      line_addr;
    logic [1:0] word_cnt;
    logic       discard;
    logic       done;
    logic       drop;
    logic       last_word;
    logic       slot_free;
    line_t      line_buf;

    assign psel = (state != ST_IDLE);
    assign penable = (state == ST_ACCESS);

    // transfer completes on an access cycle with pready
    assign done = (state == ST_ACCESS) && pready;
    assign drop = discard || redirect;
    assign last_word = (word_cnt == 2'(WORDS - 1));

    // slot of the line we want next must be empty before starting
    assign slot_free = !slot_valid[line_addr[WINDOW_BITS-1:OFS_BITS]];

    assign fill_line = line_buf;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            line_addr <= {RESET_ADDR[ADDR_W-1:OFS_BITS], {OFS_BITS{1'b0}}};
            word_cnt <= '0;
            discard <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            if (redirect) begin
                line_addr <= {redirect_addr[ADDR_W-1:OFS_BITS], {OFS_BITS{1'b0}}};
            end
            case (state)
                ST_IDLE: begin
                    if (!redirect && slot_free) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    state <= ST_ACCESS;
                    if (redirect) begin
                        discard <= 1'b1;
                    end
                end
                ST_ACCESS: begin
                    if (!pready) begin
                        if (redirect) begin
                            discard <= 1'b1;
                        end
                    end else if (drop) begin
                        // stale line, throw away what was gathered
                        state <= ST_IDLE;
                        word_cnt <= '0;
                        discard <= 1'b0;
                    end else if (last_word) begin
                        state <= ST_IDLE;
                        word_cnt <= '0;
                        fill_valid <= 1'b1;
                        line_addr <= line_addr + addr_t'(LINE_BYTES);
                    end else begin
                        state <= ST_SETUP;
                        word_cnt <= word_cnt + 2'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // address and line assembly
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            paddr <= line_addr;
        end else if (done) begin
            paddr <= paddr + addr_t'(4);
        end
        if (done) begin
            line_buf[word_cnt*32 +: 32] <= prdata;
        end
        if (done && last_word) begin
            fill_slot <= paddr[WINDOW_BITS-1:OFS_BITS];
        end
    end

endmodule

// File: design/ibuf.sv
module ibuf import fetch_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        redirect,

    // from the line fetcher
    input  logic                        fill_valid,
    input  logic [1:0]                  fill_slot,
    input  line_t                       fill_line,

    // from the aligner
    input  logic                        release_en,
    input  logic [1:0]                  release_slot,

    output line_t [NUM_SLOTS-1:0]       slot_lines,
    output logic [NUM_SLOTS-1:0]        slot_valid
);

    line_t [NUM_SLOTS-1:0] lines;
    logic [NUM_SLOTS-1:0]  valid;

    //////////////////////////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////////////////////////

    // flush beats both fill and release
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            valid <= '0;
        end else begin
            if (release_en) begin
                valid[release_slot] <= 1'b0;
            end
            if (fill_valid) begin
                valid[fill_slot] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            lines[fill_slot] <= fill_line;
        end
    end

    assign slot_lines = lines;
    assign slot_valid = valid;

endmodule

// File: fetch_align/byte_rotator.sv
module byte_rotator import fetch_pkg::*; (
    input  logic [(8 << WINDOW_BITS)-1:0] window,
    input  logic [WINDOW_BITS-1:0]        amount,
    output logic [(8 << WINDOW_BITS)-1:0] rotated
);

    localparam int WIN_W = 8 << WINDOW_BITS;

    //////////////////////////////////////////////////////////////////////
    // log shifter, one stage per amount bit
    //////////////////////////////////////////////////////////////////////

    // byte i of the result is byte (i + amount) mod 64 of the window
    for (genvar k = 0; k < WINDOW_BITS; k++) begin : g_stage
        localparam int SH = 8 << k;

        logic [WIN_W-1:0] stage_in;
        logic [WIN_W-1:0] stage_out;

        if (k == 0) begin : g_first
            assign stage_in = window;
        end else begin : g_chain
            assign stage_in = g_stage[k-1].stage_out;
        end

        // low bytes wrap around to the top
        assign stage_out = amount[k] ? {stage_in[SH-1:0], stage_in[WIN_W-1:SH]}
                                     : stage_in;
    end

    assign rotated = g_stage[WINDOW_BITS-1].stage_out;

endmodule

// File: fetch_align/fetch_align.sv
module fetch_align import fetch_pkg::*; #(
    parameter addr_t RESET_ADDR = '0
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  redirect,
    input  addr_t                 redirect_addr,

    // buffer contents
    input  line_t [NUM_SLOTS-1:0] slot_lines,
    input  logic [NUM_SLOTS-1:0]  slot_valid,

    // decoder side
    input  logic                  take,
    input  logic [4:0]            length,

    output logic                  release_en,
    output logic [1:0]            release_slot,

    output line_t                 packet,
    output logic                  packet_valid
);

    localparam int OFS_BITS = $clog2(LINE_BYTES);

    addr_t      ptr;
    addr_t      ptr_seq;
    logic [1:0] cur_slot;
    logic [1:0] nxt_slot;
    logic       advance;
    logic       crosses;

    logic [(8 << WINDOW_BITS)-1:0] window;
    logic [(8 << WINDOW_BITS)-1:0] rotated;

    //////////////////////////////////////////////////////////////////////
    // pointer
    //////////////////////////////////////////////////////////////////////

    assign ptr_seq = ptr + addr_t'(length);

    assign cur_slot = ptr[WINDOW_BITS-1:OFS_BITS];
    assign nxt_slot = cur_slot + 2'd1;

    assign advance = packet_valid && take;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= RESET_ADDR;
        end else if (redirect) begin
            ptr <= redirect_addr;
        end else if (advance) begin
            ptr <= ptr_seq;
        end
    end

    // leaving the current line frees its slot
    assign crosses = (ptr_seq[ADDR_W-1:OFS_BITS] != ptr[ADDR_W-1:OFS_BITS]);
    assign release_en = advance && crosses && !redirect;
    assign release_slot = cur_slot;

    //////////////////////////////////////////////////////////////////////
    // packet
    //////////////////////////////////////////////////////////////////////

    // needs this line and the one after it
    assign packet_valid = slot_valid[cur_slot] && slot_valid[nxt_slot];

    // slot 0 lands in the low bytes, so the window is in address order
    assign window = slot_lines;

    byte_rotator u_rot (
        .window  (window),
        .amount  (ptr[WINDOW_BITS-1:0]),
        .rotated (rotated)
    );

    assign packet = rotated[8*LINE_BYTES-1:0];

endmodule

// File: design/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
    parameter addr_t RESET_ADDR = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        rst,

    // instruction memory, APB read side
    output addr_t       paddr,
    output logic        psel,
    output logic        penable,
    input  logic [31:0] prdata,
    input  logic        pready,

    // decoder
    input  logic        take,
    input  logic [4:0]  length,

    // resteer
    input  logic        redirect,
    input  addr_t       redirect_addr,

    output line_t       packet,
    output logic        packet_valid
);

    logic                  fill_valid;
    logic [1:0]            fill_slot;
    line_t                 fill_line;
    logic                  release_en;
    logic [1:0]            release_slot;
    line_t [NUM_SLOTS-1:0] slot_lines;
    logic [NUM_SLOTS-1:0]  slot_valid;

    line_fetcher #(
        .RESET_ADDR (RESET_ADDR)
    ) u_fetcher (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .slot_valid    (slot_valid),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .prdata        (prdata),
        .pready        (pready),
        .fill_valid    (fill_valid),
        .fill_slot     (fill_slot),
        .fill_line     (fill_line)
    );

    ibuf u_ibuf (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .fill_valid   (fill_valid),
        .fill_slot    (fill_slot),
        .fill_line    (fill_line),
        .release_en   (release_en),
        .release_slot (release_slot),
        .slot_lines   (slot_lines),
        .slot_valid   (slot_valid)
    );

    fetch_align #(
        .RESET_ADDR (RESET_ADDR)
    ) u_align (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .slot_lines    (slot_lines),
        .slot_valid    (slot_valid),
        .take          (take),
        .length        (length),
        .release_en    (release_en),
        .release_slot  (release_slot),
        .packet        (packet),
        .packet_valid  (packet_valid)
    );

endmodule

// File: verif/fetch_checker.sv
module fetch_checker import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t paddr,
    input  logic  psel,
    input  logic  penable,
    input  logic  pready,
    input  logic  take,
    input  logic  redirect,
    input  line_t packet,
    input  logic  packet_valid
);

    int fails = 0;

    //////////////////////////////////////////////////////////////////////
    // APB and packet protocol
    //////////////////////////////////////////////////////////////////////

    penable_after_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(psel))
    else begin
        $error("penable rose without a setup cycle");
        fails++;
    end

    // address held from setup until pready
    paddr_stable: assert property (@(posedge clk) disable iff (rst)
        psel && !(penable && pready) |=> $stable(paddr))
    else begin
        $error("paddr changed inside a transfer");
        fails++;
    end

    packet_hold: assert property (@(posedge clk) disable iff (rst)
        packet_valid && !take && !redirect |=> $stable(packet))
    else begin
        $error("packet changed while held");
        fails++;
    end

endmodule

bind fetch_top fetch_checker u_chk (
    .clk          (clk),
    .rst          (rst),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pready       (pready),
    .take         (take),
    .redirect     (redirect),
    .packet       (packet),
    .packet_valid (packet_valid)
);

// File: verif/fetch_tb.sv
module fetch_tb;
    import fetch_pkg::*;

    localparam addr_t RESET_ADDR = 32'h0001_0a36;
    localparam int STREAM_TAKES = 300;
    localparam int REDIRECTS = 40;
    localparam int WAIT_TAKES = 100;
    // about 40 cycles per take plus reset, hold and refills
    localparam int TIMEOUT_CYCLES = 40 * (STREAM_TAKES + 8 * REDIRECTS + 2 * WAIT_TAKES + 180);

    logic        clk = 1'b0;
    logic        rst;
    addr_t       paddr;
    logic        psel;
    logic        penable;
    logic [31:0] prdata = '0;
    logic        pready = 1'b0;
    logic        take;
    logic [4:0]  length;
    logic        redirect;
    addr_t       redirect_addr;
    line_t       packet;
    logic        packet_valid;

    integer     seed = 32'hd7f909af;
    int         errors = 0;
    int         checks = 0;
    int         cmp_errors = 0;
    int         cmp_checks = 0;
    int         cycles = 0;
    int         err_mark;
    int         chk_mark;
    int         wait_left = 0;
    logic       no_wait = 1'b0;
    string      test_name = "reset";
    addr_t      exp_ptr;
    addr_t      last_line = '0;
    logic [4:0] lens [WAIT_TAKES];
    line_t      seen [$];

    fetch_top #(.RESET_ADDR (RESET_ADDR)) uut (
        .clk           (clk),
        .rst           (rst),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .prdata        (prdata),
        .pready        (pready),
        .take          (take),
        .length        (length),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .packet        (packet),
        .packet_valid  (packet_valid)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // memory contents and reference
    //////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] mem_byte(input addr_t a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        return h[7:0] ^ h[23:16] ^ h[31:24];
    endfunction

    function automatic logic [31:0] mem_word(input addr_t a);
        return {mem_byte(a + 32'd3), mem_byte(a + 32'd2), mem_byte(a + 32'd1), mem_byte(a)};
    endfunction

    // sixteen bytes from a with the lowest address in the low byte
    function automatic line_t ref_packet(input addr_t a);
        line_t r;
        for (int i = 0; i < LINE_BYTES; i++) begin
            r[8*i +: 8] = mem_byte(a + addr_t'(i));
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_len();
        return 5'(($unsigned($random(seed)) % 16) + 1);
    endfunction

    // APB slave with 0 to 3 wait states unless no_wait
    always @(posedge clk) begin
        if (no_wait) begin
            pready <= 1'b1;
            prdata <= mem_word(paddr);
        end else if (psel && !penable) begin
            wait_left = $unsigned($random(seed)) % 4;
            pready <= (wait_left == 0);
            prdata <= mem_word(paddr);
        end else if (psel && penable && !pready) begin
            wait_left = wait_left - 1;
            pready <= (wait_left == 0);
        end else begin
            pready <= 1'b0;
        end
    end

    // last line whose final word came back
    always @(negedge clk) begin
        if (psel && penable && pready && paddr[3:0] == 4'hc) begin
            last_line = {paddr[31:4], 4'h0};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // comparison against the expected pointer
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            exp_ptr = RESET_ADDR;
            cmp_checks++;
            assert (!psel && !penable && !packet_valid) else begin
                $display("reset: APB or packet_valid active during reset");
                cmp_errors++;
            end
        end else if (redirect) begin
            exp_ptr = redirect_addr;
        end else if (packet_valid && take) begin
            cmp_checks++;
            assert (packet == ref_packet(exp_ptr)) else begin
                $display("Error %s: expected %h actual %h",
                         test_name, ref_packet(exp_ptr), packet);
                cmp_errors++;
            end
            exp_ptr = exp_ptr + addr_t'(length);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        err_mark = errors + cmp_errors;
        chk_mark = checks + cmp_checks;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", test_name,
                 checks + cmp_checks - chk_mark, errors + cmp_errors - err_mark);
    endtask

    // called on a rising edge and returns on the edge that advances
    task automatic take_one(input logic [4:0] len, output line_t pkt);
        take <= 1'b1;
        length <= len;
        @(negedge clk);
        while (!packet_valid) @(negedge clk);
        pkt = packet;
        @(posedge clk);
    endtask

    task automatic send_redirect(input addr_t target);
        redirect <= 1'b1;
        redirect_addr <= target;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    initial begin
        line_t pkt;
        line_t held;
        int    n;
        rst <= 1'b1;
        take <= 1'b0;
        length <= 5'd1;
        redirect <= 1'b0;
        redirect_addr <= '0;

        start_test("reset");
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        take_one(5'd4, pkt);
        end_test();

        start_test("stream");
        for (int i = 0; i < STREAM_TAKES; i++) begin
            take_one(rand_len(), pkt);
        end
        end_test();

        start_test("backpressure");
        take <= 1'b0;
        @(negedge clk);
        while (!packet_valid) @(negedge clk);
        held = packet;
        checks++;
        assert (held == ref_packet(exp_ptr)) else begin
            $display("Error %s: expected %h actual %h", test_name, ref_packet(exp_ptr), held);
            errors++;
        end
        repeat (100) begin
            @(negedge clk);
            checks++;
            assert (packet_valid && packet == held) else begin
                $display("Error %s: expected %h actual %h", test_name, held, packet);
                errors++;
            end
        end
        checks++;
        assert (last_line - {exp_ptr[31:4], 4'h0} <= 32'd48) else begin
            $display("backpressure: fetcher ran more than four lines ahead");
            errors++;
        end
        @(posedge clk);
        end_test();

        start_test("redirect");
        for (int i = 0; i < REDIRECTS; i++) begin
            n = $unsigned($random(seed)) % 4;
            for (int k = 0; k < n; k++) begin
                take_one(rand_len(), pkt);
            end
            if (i % 2 == 1) begin
                // land inside an APB transfer
                @(negedge clk);
                while (!psel) @(negedge clk);
                @(posedge clk);
            end
            send_redirect($random(seed));
            take_one(rand_len(), pkt);
        end
        end_test();

        start_test("waitstates");
        for (int i = 0; i < WAIT_TAKES; i++) begin
            lens[i] = rand_len();
        end
        for (int pass = 0; pass < 2; pass++) begin
            no_wait <= (pass == 0);
            send_redirect(32'h0000_7ff9);
            for (int i = 0; i < WAIT_TAKES; i++) begin
                take_one(lens[i], pkt);
                if (pass == 0) begin
                    seen.push_back(pkt);
                end else begin
                    checks++;
                    assert (pkt == seen[i]) else begin
                        $display("Error %s: expected %h actual %h", test_name, seen[i], pkt);
                        errors++;
                    end
                end
            end
        end
        take <= 1'b0;
        end_test();

        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 checks + cmp_checks, errors + cmp_errors, uut.u_chk.fails);
        if (errors + cmp_errors + uut.u_chk.fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: compile.f
common/fetch_pkg.sv
design/line_fetcher.sv
design/ibuf.sv
fetch_align/byte_rotator.sv
fetch_align/fetch_align.sv
design/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

// File: Makefile
TOP = fetch_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run $(TOP)"
	@echo "make clean  remove the Verilator output"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
